/* tests/lmem_golden.txt */
# op layer addr data name; op 0 cfg, 1 wr, 2 ld, 3 rd, 4 ul; fields hex, count decimal
# cfg: addr = block, data = shift; rd/ul: data = expected; ld with layer 1 adds a losing wr
18
1 0 1 40F38D30B289207185103081 t1_wr_l0
1 1 1 00085FB2CB2C040B14F3DFBF t1_wr_l1
3 1 1 40F38D30B289207185103081 t1_rd_bank_a
3 0 1 00085FB2CB2C040B14F3DFBF t1_rd_bank_b
1 0 2 820820820820820820820820 t2_wr_neg32
3 1 2 861861861861861861861861 t2_wr_sat
2 0 3 0000008618617DF7DF820820 t2_ld_neg32
3 0 3 0000008618617DF7DF861861 t2_ld_sat
4 0 3 F0F t4_ul_signs
2 1 4 00085F07F07FF3DFBF514514 t4_ld_and_wr
4 0 4 5F0 t4_ld_wins
0 1 0 1 t3_cfg_l1_b0
0 1 2 3 t3_cfg_l1_b2
0 0 1 2 t3_cfg_l0_b1
0 0 3 1 t3_cfg_l0_b3
3 1 1 40F38D2CA24C2071850440C2 t3_rot_l1
3 0 1 7C0021B2CB2CB14040F3DFBF t3_rot_l0
3 0 4 7C002107F07FFBFF3D514514 t5_b2b_third

/* src.f */
+incdir+logic
logic/lmem_pkg.sv
logic/lmem_shift_regs.sv
logic/lmem_write_ctrl.sv
logic/lmem_llr_bank.sv
logic/lmem_read_align.sv
logic/lmem_hd_unload.sv
logic/lmem_top.sv
tests/lmem_checker.sv
tests/lmem_properties.sv
tests/lmem_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module lmem_tb -f src.f -o Vlmem_tb
out=$(./obj_dir/Vlmem_tb +verilator+error+limit+100 2>&1) || true
echo "$out"
echo "$out" | grep -qx "Simulation finished: PASS"

/* tests/lmem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lmem_tb import lmem_pkg::*; ();

  logic         clk = 1'b0;
  logic         rst;
  logic         i_cfg_req;
  logic         i_cfg_layer;
  logic   [1:0] i_cfg_block;
  shift_t       i_cfg_shift;
  logic         o_cfg_ack;
  logic         i_wr_en;
  logic         i_wr_layer;
  addr_t        i_wr_addr;
  row_word_t    i_wr_data;
  logic         i_load_en;
  row_word_t    i_load_data;
  logic         i_rd_en;
  logic         i_rd_layer;
  addr_t        i_rd_addr;
  row_word_t    o_rd_data;
  logic         o_rd_valid;
  logic         i_unload_en;
  addr_t        i_unload_addr;
  hd_word_t     o_hd_data;
  logic         o_hd_valid;

  // expectations towards the checker
  logic         push_rd;
  logic         push_ul;
  row_word_t    exp_rd;
  hd_word_t     exp_ul;
  logic [127:0] exp_name;
  int           mismatch_cnt;
  int           other_cnt;
  int           pending_cnt;

  // golden operations, one entry per line
  lmem_op_t     op_q[$];
  logic         layer_q[$];
  addr_t        addr_q[$];
  row_word_t    data_q[$];
  logic [127:0] name_q[$];
  int           n_ops = 0;
  bit           file_ok;
  int           total_err;

  always #50 clk = ~clk;  // 100 ns period

  lmem_top i_dut (
    .clk(clk), .rst(rst),
    .i_cfg_req(i_cfg_req), .i_cfg_layer(i_cfg_layer), .i_cfg_block(i_cfg_block),
    .i_cfg_shift(i_cfg_shift), .o_cfg_ack(o_cfg_ack),
    .i_wr_en(i_wr_en), .i_wr_layer(i_wr_layer), .i_wr_addr(i_wr_addr),
    .i_wr_data(i_wr_data), .i_load_en(i_load_en), .i_load_data(i_load_data),
    .i_rd_en(i_rd_en), .i_rd_layer(i_rd_layer), .i_rd_addr(i_rd_addr),
    .o_rd_data(o_rd_data), .o_rd_valid(o_rd_valid),
    .i_unload_en(i_unload_en), .i_unload_addr(i_unload_addr),
    .o_hd_data(o_hd_data), .o_hd_valid(o_hd_valid)
  );

  lmem_checker u_chk (
    .clk(clk), .rst(rst),
    .i_push_rd(push_rd), .i_exp_rd(exp_rd), .i_push_ul(push_ul), .i_exp_ul(exp_ul),
    .i_name(exp_name),
    .i_rd_valid(o_rd_valid), .i_rd_data(o_rd_data),
    .i_hd_valid(o_hd_valid), .i_hd_data(o_hd_data),
    .o_mismatch_cnt(mismatch_cnt), .o_other_cnt(other_cnt), .o_pending(pending_cnt)
  );

  ////////////////////////////////////////////////////////////////////////////
  // golden file, '#' lines skipped, then count, then one op per line
  ////////////////////////////////////////////////////////////////////////////
  task automatic read_golden(output bit ok);
    int           fd;
    int           rc;
    int           count;
    string        line;
    logic   [2:0] f_op;
    logic         f_layer;
    addr_t        f_addr;
    row_word_t    f_data;
    logic [127:0] f_name;
    ok = 1'b0;
    count = -1;
    fd = $fopen("tests/lmem_golden.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open tests/lmem_golden.txt");
    end else begin
      while (!$feof(fd)) begin
        rc = $fgets(line, fd);
        if (rc > 1 && line.getc(0) != "#") begin
          if (count < 0) begin
            rc = $sscanf(line, "%d", count);
          end else begin
            rc = $sscanf(line, "%h %h %h %h %s", f_op, f_layer, f_addr, f_data, f_name);
            if (rc == 5) begin
              op_q.push_back(lmem_op_t'(f_op));
              layer_q.push_back(f_layer);
              addr_q.push_back(f_addr);
              data_q.push_back(f_data);
              name_q.push_back(f_name);
            end
          end
        end
      end
      $fclose(fd);
      ok = (count > 0) && (op_q.size() == count);
      if (!ok) $display("ERROR: golden file has %0d ops, its header says %0d", op_q.size(), count);
    end
  endtask

  task automatic clear_strobes();
    i_wr_en     <= 1'b0;
    i_load_en   <= 1'b0;
    i_rd_en     <= 1'b0;
    i_unload_en <= 1'b0;
    push_rd     <= 1'b0;
    push_ul     <= 1'b0;
  endtask

  // four-phase: req up, wait ack, req down, wait ack low
  task automatic write_shift(input logic layer, input addr_t block, input row_word_t shift);
    i_cfg_req   <= 1'b1;
    i_cfg_layer <= layer;
    i_cfg_block <= 2'(block);
    i_cfg_shift <= shift_t'(shift);
    @(negedge clk);
    while (!o_cfg_ack) @(negedge clk);
    @(posedge clk);
    i_cfg_req <= 1'b0;
    @(negedge clk);
    while (o_cfg_ack) @(negedge clk);
  endtask

  task automatic run_ops();
    for (int k = 0; k < op_q.size(); k++) begin
      @(posedge clk);
      clear_strobes();
      exp_name <= name_q[k];
      case (op_q[k])
        OP_CFG: write_shift(layer_q[k], addr_q[k], data_q[k]);
        OP_WR: begin
          i_wr_en    <= 1'b1;
          i_wr_layer <= layer_q[k];
          i_wr_addr  <= addr_q[k];
          i_wr_data  <= data_q[k];
        end
        OP_LD: begin
          i_load_en   <= 1'b1;
          i_wr_addr   <= addr_q[k];
          i_load_data <= data_q[k];
          if (layer_q[k]) begin  // competing layer-1 write, must lose
            i_wr_en    <= 1'b1;
            i_wr_layer <= 1'b1;
            i_wr_data  <= ~data_q[k];
          end
        end
        OP_RD: begin
          i_rd_en    <= 1'b1;
          i_rd_layer <= layer_q[k];
          i_rd_addr  <= addr_q[k];
          push_rd    <= 1'b1;
          exp_rd     <= data_q[k];  // already rotated offline
        end
        OP_UL: begin
          i_unload_en   <= 1'b1;
          i_unload_addr <= addr_q[k];
          push_ul       <= 1'b1;
          exp_ul        <= hd_word_t'(data_q[k]);
        end
      endcase
    end
    @(posedge clk);
    clear_strobes();
  endtask

  initial begin : stimulus
    rst           <= 1'b1;
    i_cfg_req     <= 1'b0;
    i_cfg_layer   <= 1'b0;
    i_cfg_block   <= '0;
    i_cfg_shift   <= '0;
    i_wr_en       <= 1'b0;
    i_wr_layer    <= 1'b0;
    i_wr_addr     <= '0;
    i_wr_data     <= '0;
    i_load_en     <= 1'b0;
    i_load_data   <= '0;
    i_rd_en       <= 1'b0;
    i_rd_layer    <= 1'b0;
    i_rd_addr     <= '0;
    i_unload_en   <= 1'b0;
    i_unload_addr <= '0;
    push_rd       <= 1'b0;
    push_ul       <= 1'b0;
    exp_rd        <= '0;
    exp_ul        <= '0;
    exp_name      <= '0;
    read_golden(file_ok);
    n_ops = op_q.size();
    if (!file_ok) begin
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      run_ops();
      @(negedge clk);
      while (pending_cnt != 0) @(negedge clk);  // drain in-flight reads
      repeat (3) @(negedge clk);                 // catch stray valids
      total_err = mismatch_cnt + other_cnt + i_dut.u_props.fail_cnt;
      $display("errors: %0d mismatches, %0d other, %0d assertions",
               mismatch_cnt, other_cnt, i_dut.u_props.fail_cnt);
      if (total_err == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

  // budget of 10 cycles per op plus slack
  initial begin : watchdog
    wait (n_ops > 0);
    repeat (n_ops * 10 + 100) @(posedge clk);
    $display("ERROR: timeout, run still busy after %0d cycles", n_ops * 10 + 100);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/lmem_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module lmem_properties (
  input wire clk,
  input wire rst,
  input wire i_rd_en,
  input wire o_rd_valid,
  input wire i_unload_en,
  input wire o_hd_valid,
  input wire i_cfg_req,
  input wire o_cfg_ack
);

  int fail_cnt = 0;  // read back by the testbench

  ////////////////////////////////////////////////////////////////////////////
  // fixed 2-cycle output latency
  ////////////////////////////////////////////////////////////////////////////
  a_rd_latency: assert property (@(posedge clk) disable iff (rst)
    o_rd_valid == $past(i_rd_en, 2))
    else begin
      $error("o_rd_valid not exactly 2 cycles after i_rd_en");
      fail_cnt++;
    end

  a_hd_latency: assert property (@(posedge clk) disable iff (rst)
    o_hd_valid == $past(i_unload_en, 2))
    else begin
      $error("o_hd_valid not exactly 2 cycles after i_unload_en");
      fail_cnt++;
    end

  // four-phase config port
  a_ack_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(o_cfg_ack) |-> $past(i_cfg_req))
    else begin
      $error("o_cfg_ack rose without i_cfg_req");
      fail_cnt++;
    end

  a_ack_fall: assert property (@(posedge clk) disable iff (rst)
    $fell(o_cfg_ack) |-> !$past(i_cfg_req))
    else begin
      $error("o_cfg_ack fell while i_cfg_req still high");
      fail_cnt++;
    end

endmodule

bind lmem_top lmem_properties u_props (
  .clk(clk), .rst(rst),
  .i_rd_en(i_rd_en), .o_rd_valid(o_rd_valid),
  .i_unload_en(i_unload_en), .o_hd_valid(o_hd_valid),
  .i_cfg_req(i_cfg_req), .o_cfg_ack(o_cfg_ack)
);

`default_nettype wire

/* tests/lmem_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module lmem_checker import lmem_pkg::*; (
  input  wire          clk,
  input  wire          rst,
  input  wire          i_push_rd,
  input  row_word_t    i_exp_rd,
  input  wire          i_push_ul,
  input  hd_word_t     i_exp_ul,
  input  wire  [127:0] i_name,      // ascii test name
  input  wire          i_rd_valid,
  input  row_word_t    i_rd_data,
  input  wire          i_hd_valid,
  input  hd_word_t     i_hd_data,
  output int           o_mismatch_cnt,
  output int           o_other_cnt,
  output int           o_pending
);

  row_word_t    rd_exp_q[$];
  logic [127:0] rd_name_q[$];
  hd_word_t     ul_exp_q[$];
  logic [127:0] ul_name_q[$];
  int           mismatch_cnt = 0;
  int           other_cnt = 0;
  int           pending = 0;

  ////////////////////////////////////////////////////////////////////////////
  // push on request, pop and compare on each valid pulse
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin : compare
    row_word_t    rd_exp;
    hd_word_t     ul_exp;
    logic [127:0] name;
    if (rst) begin
      rd_exp_q.delete();
      rd_name_q.delete();
      ul_exp_q.delete();
      ul_name_q.delete();
    end else begin
      if (i_push_rd) begin
        rd_exp_q.push_back(i_exp_rd);
        rd_name_q.push_back(i_name);
      end
      if (i_push_ul) begin
        ul_exp_q.push_back(i_exp_ul);
        ul_name_q.push_back(i_name);
      end
      if (i_rd_valid) begin
        if (rd_exp_q.size() == 0) begin
          $display("ERROR: read data came out with no read pending");
          other_cnt++;
        end else begin
          rd_exp = rd_exp_q.pop_front();
          name   = rd_name_q.pop_front();
          if (i_rd_data !== rd_exp) begin
            $display("FAILED %0s: expected %h, actual %h", name, rd_exp, i_rd_data);
            mismatch_cnt++;
          end
        end
      end
      if (i_hd_valid) begin
        if (ul_exp_q.size() == 0) begin
          $display("ERROR: hard decisions came out with no unload pending");
          other_cnt++;
        end else begin
          ul_exp = ul_exp_q.pop_front();
          name   = ul_name_q.pop_front();
          if (i_hd_data !== ul_exp) begin
            $display("FAILED %0s: expected %h, actual %h", name, ul_exp, i_hd_data);
            mismatch_cnt++;
          end
        end
      end
    end
    pending = rd_exp_q.size() + ul_exp_q.size();
  end

  assign o_mismatch_cnt = mismatch_cnt;
  assign o_other_cnt    = other_cnt;
  assign o_pending      = pending;

endmodule

`default_nettype wire

/* logic/lmem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lmem_top import lmem_pkg::*; (
  input  wire        clk,
  input  wire        rst,
  // shift config, four-phase
  input  wire        i_cfg_req,
  input  wire        i_cfg_layer,
  input  wire  [1:0] i_cfg_block,
  input  shift_t     i_cfg_shift,
  output logic       o_cfg_ack,
  // decoder write back
  input  wire        i_wr_en,
  input  wire        i_wr_layer,
  input  addr_t      i_wr_addr,    // also the load address
  input  row_word_t  i_wr_data,
  // channel load
  input  wire        i_load_en,
  input  row_word_t  i_load_data,
  // decoder read
  input  wire        i_rd_en,
  input  wire        i_rd_layer,
  input  addr_t      i_rd_addr,
  output row_word_t  o_rd_data,
  output logic       o_rd_valid,
  // hard decision unload
  input  wire        i_unload_en,
  input  addr_t      i_unload_addr,
  output hd_word_t   o_hd_data,
  output logic       o_hd_valid
);

  shift_tab_t shift_l0;
  shift_tab_t shift_l1;
  row_word_t  wr_row;     // saturated write or load word
  logic       we_a;
  logic       we_b;
  row_word_t  bank_a_rd;
  row_word_t  bank_b_rd;
  row_word_t  bank_b_ul;

  ////////////////////////////////////////////////////////////////////////////
  // control and write path
  ////////////////////////////////////////////////////////////////////////////
  lmem_shift_regs u_shift_regs (
    .clk(clk), .rst(rst),
    .i_cfg_req(i_cfg_req), .i_cfg_layer(i_cfg_layer),
    .i_cfg_block(i_cfg_block), .i_cfg_shift(i_cfg_shift),
    .o_cfg_ack(o_cfg_ack),
    .o_shift_l0(shift_l0), .o_shift_l1(shift_l1)
  );

  lmem_write_ctrl u_write_ctrl (
    .i_wr_en(i_wr_en), .i_wr_layer(i_wr_layer), .i_load_en(i_load_en),
    .i_wr_data(i_wr_data), .i_load_data(i_load_data),
    .o_we_a(we_a), .o_we_b(we_b), .o_data(wr_row)
  );

  ////////////////////////////////////////////////////////////////////////////
  // storage, a = layer 0 results, b = layer 1 results + channel
  ////////////////////////////////////////////////////////////////////////////
  lmem_llr_bank #(.UNLOAD_PORT(0)) u_bank_a (
    .clk(clk), .i_we(we_a), .i_wr_addr(i_wr_addr), .i_wr_data(wr_row),
    .i_rd_addr(i_rd_addr), .i_ul_addr('0),  // no unload port on a
    .o_rd_data(bank_a_rd), .o_ul_data()
  );

  lmem_llr_bank #(.UNLOAD_PORT(1)) u_bank_b (
    .clk(clk), .i_we(we_b), .i_wr_addr(i_wr_addr), .i_wr_data(wr_row),
    .i_rd_addr(i_rd_addr), .i_ul_addr(i_unload_addr),
    .o_rd_data(bank_b_rd), .o_ul_data(bank_b_ul)
  );

  ////////////////////////////////////////////////////////////////////////////
  // output paths
  ////////////////////////////////////////////////////////////////////////////
  lmem_read_align u_read_align (
    .clk(clk), .rst(rst), .i_rd_en(i_rd_en), .i_rd_layer(i_rd_layer),
    .i_bank_a(bank_a_rd), .i_bank_b(bank_b_rd),
    .i_shift_l0(shift_l0), .i_shift_l1(shift_l1),
    .o_rd_data(o_rd_data), .o_rd_valid(o_rd_valid)
  );

  lmem_hd_unload u_hd_unload (
    .clk(clk), .rst(rst), .i_unload_en(i_unload_en), .i_ul_data(bank_b_ul),
    .o_hd_data(o_hd_data), .o_hd_valid(o_hd_valid)
  );

endmodule

`default_nettype wire

/* logic/lmem_hd_unload.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lmem_settings.svh"

module lmem_hd_unload import lmem_pkg::*; (
  input  wire       clk,
  input  wire       rst,
  input  wire       i_unload_en,
  input  row_word_t i_ul_data,   // bank b, unrotated
  output hd_word_t  o_hd_data,
  output logic      o_hd_valid
);

  logic     ul_en_q;
  hd_word_t hd_bits;

  always_ff @(posedge clk) begin
    if (rst) begin
      ul_en_q    <= 1'b0;
      o_hd_valid <= 1'b0;
    end else begin
      ul_en_q    <= i_unload_en;  // matches bank read latency
      o_hd_valid <= ul_en_q;
    end
  end

  // hard decision = llr sign, systematic blocks only
  always_comb begin
    for (int b = 0; b < `LMEM_SYS_KB; b++) begin
      for (int j = 0; j < `LMEM_ROWS_P; j++) begin
        hd_bits[b*`LMEM_ROWS_P + j] = i_ul_data[b][j][`LMEM_LLR_W-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    o_hd_data <= hd_bits;
  end

endmodule

`default_nettype wire

/* logic/lmem_read_align.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lmem_settings.svh"

module lmem_read_align import lmem_pkg::*; (
  input  wire        clk,
  input  wire        rst,
  input  wire        i_rd_en,
  input  wire        i_rd_layer,
  input  row_word_t  i_bank_a,     // layer 0 results
  input  row_word_t  i_bank_b,     // layer 1 results and channel llrs
  input  shift_tab_t i_shift_l0,
  input  shift_tab_t i_shift_l1,
  output row_word_t  o_rd_data,
  output logic       o_rd_valid
);

  logic       rd_en_q;     // aligned with bank output
  logic       rd_layer_q;
  row_word_t  sel_word;
  shift_tab_t sel_shift;
  row_word_t  rot_word;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1, track the bank read
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) rd_en_q <= 1'b0;
    else     rd_en_q <= i_rd_en;
  end

  always_ff @(posedge clk) begin
    rd_layer_q <= i_rd_layer;
  end

  // layer 1 reads what layer 0 wrote
  assign sel_word  = rd_layer_q ? i_bank_a : i_bank_b;
  assign sel_shift = rd_layer_q ? i_shift_l1 : i_shift_l0;  // sampled as data leaves bank

  // cyclic lane rotation per block, out j <- in (j+s) mod p
  always_comb begin
    for (int b = 0; b < `LMEM_BLOCKS_NB; b++) begin
      for (int j = 0; j < `LMEM_ROWS_P; j++) begin
        rot_word[b][j] = sel_word[b][(j + int'(sel_shift[b])) % `LMEM_ROWS_P];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 2, output register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) o_rd_valid <= 1'b0;
    else     o_rd_valid <= rd_en_q;  // pulse, 2 cycles after i_rd_en
  end

  always_ff @(posedge clk) begin
    o_rd_data <= rot_word;
  end

endmodule

`default_nettype wire

/* logic/lmem_llr_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lmem_settings.svh"

module lmem_llr_bank import lmem_pkg::*; #(
  parameter int UNLOAD_PORT = 0  // 1 -> extra read port for hard decisions
) (
  input  wire       clk,
  input  wire       i_we,
  input  addr_t     i_wr_addr,
  input  row_word_t i_wr_data,
  input  addr_t     i_rd_addr,
  input  addr_t     i_ul_addr,
  output row_word_t o_rd_data,
  output row_word_t o_ul_data
);

  row_word_t mem [`LMEM_DEPTH];

  // write and main read share the edge, read sees the old word
  always_ff @(posedge clk) begin
    if (i_we) mem[i_wr_addr] <= i_wr_data;
    o_rd_data <= mem[i_rd_addr];
  end

  generate
    if (UNLOAD_PORT != 0) begin : g_ul_port
      row_word_t ul_q;
      always_ff @(posedge clk) begin
        ul_q <= mem[i_ul_addr];  // same 1-cycle latency as rd port
      end
      assign o_ul_data = ul_q;
    end else begin : g_no_ul_port
      assign o_ul_data = '0;
    end
  endgenerate

endmodule

`default_nettype wire

/* logic/lmem_write_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lmem_settings.svh"

module lmem_write_ctrl import lmem_pkg::*; (
  input  wire       i_wr_en,
  input  wire       i_wr_layer,   // 0 -> bank a, 1 -> bank b
  input  wire       i_load_en,    // channel llrs, always bank b
  input  row_word_t i_wr_data,
  input  row_word_t i_load_data,
  output logic      o_we_a,
  output logic      o_we_b,
  output row_word_t o_data
);

  localparam llr_t LLR_POS = llr_t'(`LMEM_LLR_MAX);
  localparam llr_t LLR_NEG = -LLR_POS;  // symmetric range, -32 never stored

  row_word_t sel_data;

  // clip one lane to +-llr_max
  function automatic llr_t sat_llr(input llr_t v);
    if (v > LLR_POS) return LLR_POS;
    if (v < LLR_NEG) return LLR_NEG;
    return v;
  endfunction

  assign sel_data = i_load_en ? i_load_data : i_wr_data;  // load wins

  always_comb begin
    for (int b = 0; b < `LMEM_BLOCKS_NB; b++) begin
      for (int j = 0; j < `LMEM_ROWS_P; j++) begin
        o_data[b][j] = sat_llr(sel_data[b][j]);
      end
    end
  end

  // bank routing, write dropped when a load is present
  assign o_we_a = i_wr_en & ~i_load_en & ~i_wr_layer;
  assign o_we_b = i_load_en | (i_wr_en & i_wr_layer);

endmodule

`default_nettype wire

/* logic/lmem_shift_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module lmem_shift_regs import lmem_pkg::*; (
  input  wire        clk,
  input  wire        rst,
  input  wire        i_cfg_req,
  input  wire        i_cfg_layer,  // 0 -> l0 table, 1 -> l1 table
  input  wire  [1:0] i_cfg_block,
  input  shift_t     i_cfg_shift,
  output logic       o_cfg_ack,
  output shift_tab_t o_shift_l0,
  output shift_tab_t o_shift_l1
);

  cfg_state_t state;

  ////////////////////////////////////////////////////////////////////////////
  // handshake fsm, table write on req accept
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= CFG_IDLE;
      o_shift_l0 <= '0;  // no rotation out of reset
      o_shift_l1 <= '0;
    end else begin
      case (state)
        CFG_IDLE: begin
          if (i_cfg_req) begin  // first edge with req -> take entry
            if (i_cfg_layer) begin
              o_shift_l1[i_cfg_block] <= i_cfg_shift;
            end else begin
              o_shift_l0[i_cfg_block] <= i_cfg_shift;
            end
            state <= CFG_ACK;
          end
        end
        CFG_ACK: begin
          if (!i_cfg_req) state <= CFG_IDLE;  // host dropped req, release ack
        end
        default: state <= CFG_IDLE;
      endcase
    end
  end

  assign o_cfg_ack = (state == CFG_ACK);  // held until req falls

endmodule

`default_nettype wire

/* logic/lmem_pkg.sv */
`default_nettype none

`include "lmem_settings.svh"

package lmem_pkg;

  typedef logic signed [`LMEM_LLR_W-1:0] llr_t;              // one llr
  typedef llr_t [`LMEM_ROWS_P-1:0] blk_word_t;                // lane j at index j
  typedef blk_word_t [`LMEM_BLOCKS_NB-1:0] row_word_t;        // block b at index b
  typedef logic [`LMEM_ADDR_W-1:0] addr_t;
  typedef logic [`LMEM_SHIFT_W-1:0] shift_t;
  typedef shift_t [`LMEM_BLOCKS_NB-1:0] shift_tab_t;          // one shift per block
  typedef logic [`LMEM_SYS_KB*`LMEM_ROWS_P-1:0] hd_word_t;    // bit b*p+j

  // four-phase config handshake
  typedef enum logic {CFG_IDLE, CFG_ACK} cfg_state_t;

  // golden file opcodes
  typedef enum logic [2:0] {OP_CFG, OP_WR, OP_LD, OP_RD, OP_UL} lmem_op_t;

endpackage

`default_nettype wire

/* logic/lmem_settings.svh */
`ifndef LMEM_SETTINGS_SVH
`define LMEM_SETTINGS_SVH

// llr format
`define LMEM_LLR_W      6    // bits per llr, two's complement
`define LMEM_LLR_MAX    31   // clip magnitude

// quasi-cyclic geometry
`define LMEM_ROWS_P     4    // lanes per circulant block
`define LMEM_BLOCKS_NB  4    // circulant blocks per row word
`define LMEM_SYS_KB     3    // systematic blocks, first kb

// bank geometry
`define LMEM_DEPTH      8    // words per bank
`define LMEM_ADDR_W     3    // clog2 of depth
`define LMEM_SHIFT_W    2    // clog2 of rows_p

`endif
